// File: hdl/axi_rd_consts.svh
`ifndef AXI_RD_CONSTS_SVH
`define AXI_RD_CONSTS_SVH

// Bus widths in bits
`define AXI_ADDR_WIDTH 8
`define AXI_DATA_WIDTH 16
`define AXI_ID_WIDTH 4

// Reflector queue holds 2**OUTSTANDING_WIDTH reads in flight
`define OUTSTANDING_WIDTH 1

// AXI response codes
`define RESP_OKAY 2'd0
`define RESP_SLVERR 2'd2

`endif

// File: hdl/axi_burst_pkg.sv
`default_nettype none

`include "axi_rd_consts.svh"

package axi_burst_pkg;

  // Byte address and transaction ID
  typedef logic [`AXI_ADDR_WIDTH-1:0] addr_t;
  typedef logic [`AXI_ID_WIDTH-1:0] id_t;

  // Beat count minus one, as carried on ARLEN
  typedef logic [7:0] len_t;

  // Log2 of bytes per beat
  typedef logic [2:0] size_t;

  // Burst type codes
  typedef logic [1:0] burst_t;

  localparam burst_t BURST_FIXED = 2'd0;
  localparam burst_t BURST_INCR = 2'd1;
  localparam burst_t BURST_WRAP = 2'd2;

  // Burst iterator FSM
  typedef enum logic {
    ITER_IDLE,
    ITER_BEATS
  } iter_state_t;

endpackage

`default_nettype wire

// File: hdl/axil_beat_pkg.sv
`default_nettype none

`include "axi_rd_consts.svh"

package axil_beat_pkg;

  // Read data beat
  typedef logic [`AXI_DATA_WIDTH-1:0] data_t;

  // RRESP code
  typedef logic [1:0] resp_t;

  // Queue pointer, MSB tells full from empty
  typedef logic [`OUTSTANDING_WIDTH:0] qptr_t;

endpackage

`default_nettype wire

// File: hdl/axi_burst_iter_ar.sv
`timescale 1ns/1ns
`default_nettype none

module axi_burst_iter_ar (
  input  wire                    clk,
  input  wire                    i_reset,

  // AXI read address channel
  input  wire                    i_s_arvalid,
  input  wire axi_burst_pkg::id_t    i_s_arid,
  input  wire axi_burst_pkg::addr_t  i_s_araddr,
  input  wire axi_burst_pkg::len_t   i_s_arlen,
  input  wire axi_burst_pkg::size_t  i_s_arsize,
  input  wire axi_burst_pkg::burst_t i_s_arburst,
  output logic                   o_s_arready,

  // Single-beat requests
  output logic                   o_beat_valid,
  output axi_burst_pkg::addr_t   o_beat_addr,
  output axi_burst_pkg::id_t     o_beat_id,
  output logic                   o_beat_last,
  input  wire                    i_beat_ready
);

  import axi_burst_pkg::*;

  iter_state_t state;
  len_t        beats_left;

  addr_t       addr_q;
  id_t         id_q;
  size_t       size_q;
  burst_t      burst_q;
  addr_t       wrap_mask;

  addr_t       step;
  addr_t       addr_next;
  logic [15:0] wrap_bytes;

  logic        ar_xfer;
  logic        beat_xfer;

  assign o_s_arready = (state == ITER_IDLE);
  assign ar_xfer = i_s_arvalid && o_s_arready;

  assign o_beat_valid = (state == ITER_BEATS);
  assign o_beat_addr = addr_q;
  assign o_beat_id = id_q;
  assign o_beat_last = o_beat_valid && (beats_left == '0);
  assign beat_xfer = o_beat_valid && i_beat_ready;

  // WRAP window in bytes is beat count times bytes per beat
  assign wrap_bytes = ({8'd0, i_s_arlen} + 16'd1) << i_s_arsize;

  assign step = addr_t'(1) << size_q;

  always_comb begin
    case (burst_q)
      BURST_FIXED: begin
        addr_next = addr_q;
      end
      BURST_INCR: begin
        addr_next = addr_q + step;
      end
      BURST_WRAP: begin
        // Keep the upper bits, wrap only inside the window
        addr_next = (addr_q & ~wrap_mask) | ((addr_q + step) & wrap_mask);
      end
      default: begin
        addr_next = addr_q + step;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (i_reset) begin
      state <= ITER_IDLE;
      beats_left <= '0;
    end else begin
      case (state)
        ITER_IDLE: begin
          if (ar_xfer) begin
            state <= ITER_BEATS;
            beats_left <= i_s_arlen;
          end
        end
        ITER_BEATS: begin
          if (beat_xfer) begin
            if (o_beat_last) begin
              state <= ITER_IDLE;
            end else begin
              beats_left <= beats_left - 8'd1;
            end
          end
        end
        default: begin
          state <= ITER_IDLE;
        end
      endcase
    end
  end

  // Burst payload, latched on AR and stepped per beat
  always_ff @(posedge clk) begin
    if (ar_xfer) begin
      addr_q <= i_s_araddr;
      id_q <= i_s_arid;
      size_q <= i_s_arsize;
      burst_q <= i_s_arburst;
      wrap_mask <= addr_t'(wrap_bytes - 16'd1);
    end else if (beat_xfer) begin
      addr_q <= addr_next;
    end
  end

endmodule

`default_nettype wire

// File: hdl/axil_reflect_rd.sv
`timescale 1ns/1ns
`default_nettype none

`include "axi_rd_consts.svh"

module axil_reflect_rd (
  input  wire                        clk,
  input  wire                        i_reset,

  // Single-beat requests from the iterator
  input  wire                        i_beat_valid,
  input  wire axi_burst_pkg::addr_t  i_beat_addr,
  input  wire axi_burst_pkg::id_t    i_beat_id,
  input  wire                        i_beat_last,
  output logic                       o_beat_ready,

  // AXI-Lite read manager
  output logic                       o_m_arvalid,
  output axi_burst_pkg::addr_t       o_m_araddr,
  input  wire                        i_m_arready,
  input  wire                        i_m_rvalid,
  input  wire axil_beat_pkg::data_t  i_m_rdata,
  input  wire axil_beat_pkg::resp_t  i_m_rresp,
  output logic                       o_m_rready,

  // AXI read data channel
  output logic                       o_s_rvalid,
  output axi_burst_pkg::id_t         o_s_rid,
  output axil_beat_pkg::data_t       o_s_rdata,
  output axil_beat_pkg::resp_t       o_s_rresp,
  output logic                       o_s_rlast,
  input  wire                        i_s_rready
);

  import axi_burst_pkg::*;
  import axil_beat_pkg::*;

  localparam int QDEPTH = 1 << `OUTSTANDING_WIDTH;

  // ID and last tag of each read in flight, oldest at rd_ptr
  id_t   q_id [QDEPTH];
  logic  q_last [QDEPTH];

  qptr_t wr_ptr;
  qptr_t rd_ptr;
  logic [`OUTSTANDING_WIDTH-1:0] wr_idx;
  logic [`OUTSTANDING_WIDTH-1:0] rd_idx;

  logic  q_empty;
  logic  q_full;
  logic  push;
  logic  pop;

  assign wr_idx = wr_ptr[`OUTSTANDING_WIDTH-1:0];
  assign rd_idx = rd_ptr[`OUTSTANDING_WIDTH-1:0];

  assign q_empty = (wr_ptr == rd_ptr);
  // Same slot, opposite lap
  assign q_full = (wr_ptr[`OUTSTANDING_WIDTH] != rd_ptr[`OUTSTANDING_WIDTH]) &&
                  (wr_idx == rd_idx);

  // Address path, stalled while the queue is full
  assign o_m_arvalid = i_beat_valid && !q_full;
  assign o_m_araddr = i_beat_addr;
  assign o_beat_ready = i_m_arready && !q_full;
  assign push = o_m_arvalid && i_m_arready;

  // Response path, only with a read outstanding
  assign o_s_rvalid = i_m_rvalid && !q_empty;
  assign o_m_rready = i_s_rready && !q_empty;
  assign pop = o_s_rvalid && i_s_rready;

  assign o_s_rid = q_id[rd_idx];
  assign o_s_rdata = i_m_rdata;
  assign o_s_rresp = i_m_rresp;
  assign o_s_rlast = q_last[rd_idx] && !q_empty;

  always_ff @(posedge clk) begin
    if (i_reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + qptr_t'(1);
      end
      if (pop) begin
        rd_ptr <= rd_ptr + qptr_t'(1);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      q_id[wr_idx] <= i_beat_id;
      q_last[wr_idx] <= i_beat_last;
    end
  end

endmodule

`default_nettype wire

// File: hdl/axi_axil_adapter_rd.sv
`timescale 1ns/1ns
`default_nettype none

module axi_axil_adapter_rd (
  input  wire                        clk,
  input  wire                        i_reset,

  // AXI subordinate side
  input  wire                        i_s_arvalid,
  input  wire axi_burst_pkg::id_t    i_s_arid,
  input  wire axi_burst_pkg::addr_t  i_s_araddr,
  input  wire axi_burst_pkg::len_t   i_s_arlen,
  input  wire axi_burst_pkg::size_t  i_s_arsize,
  input  wire axi_burst_pkg::burst_t i_s_arburst,
  output logic                       o_s_arready,
  output logic                       o_s_rvalid,
  output axi_burst_pkg::id_t         o_s_rid,
  output axil_beat_pkg::data_t       o_s_rdata,
  output axil_beat_pkg::resp_t       o_s_rresp,
  output logic                       o_s_rlast,
  input  wire                        i_s_rready,

  // AXI-Lite manager side
  output logic                       o_m_arvalid,
  output axi_burst_pkg::addr_t       o_m_araddr,
  input  wire                        i_m_arready,
  input  wire                        i_m_rvalid,
  input  wire axil_beat_pkg::data_t  i_m_rdata,
  input  wire axil_beat_pkg::resp_t  i_m_rresp,
  output logic                       o_m_rready
);

  import axi_burst_pkg::*;

  // Beat requests from iterator to reflector
  logic  beat_valid;
  addr_t beat_addr;
  id_t   beat_id;
  logic  beat_last;
  logic  beat_ready;

  axi_burst_iter_ar iter_i (
    .clk          (clk),
    .i_reset      (i_reset),
    .i_s_arvalid  (i_s_arvalid),
    .i_s_arid     (i_s_arid),
    .i_s_araddr   (i_s_araddr),
    .i_s_arlen    (i_s_arlen),
    .i_s_arsize   (i_s_arsize),
    .i_s_arburst  (i_s_arburst),
    .o_s_arready  (o_s_arready),
    .o_beat_valid (beat_valid),
    .o_beat_addr  (beat_addr),
    .o_beat_id    (beat_id),
    .o_beat_last  (beat_last),
    .i_beat_ready (beat_ready)
  );

  // RLAST comes back from the tag stored at AR time
  axil_reflect_rd reflect_i (
    .clk          (clk),
    .i_reset      (i_reset),
    .i_beat_valid (beat_valid),
    .i_beat_addr  (beat_addr),
    .i_beat_id    (beat_id),
    .i_beat_last  (beat_last),
    .o_beat_ready (beat_ready),
    .o_m_arvalid  (o_m_arvalid),
    .o_m_araddr   (o_m_araddr),
    .i_m_arready  (i_m_arready),
    .i_m_rvalid   (i_m_rvalid),
    .i_m_rdata    (i_m_rdata),
    .i_m_rresp    (i_m_rresp),
    .o_m_rready   (o_m_rready),
    .o_s_rvalid   (o_s_rvalid),
    .o_s_rid      (o_s_rid),
    .o_s_rdata    (o_s_rdata),
    .o_s_rresp    (o_s_rresp),
    .o_s_rlast    (o_s_rlast),
    .i_s_rready   (i_s_rready)
  );

endmodule

`default_nettype wire

// File: tb/tb_clkgen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clkgen (
  output logic clk,
  output logic o_reset
);

  localparam int HALF_PERIOD = 20;
  localparam int RESET_CYCLES = 3;

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  // Reset released on the rising edge after the last reset cycle
  initial begin
    o_reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    o_reset <= 1'b0;
  end

endmodule

`default_nettype wire

// File: tb/axi_axil_adapter_rd_assertions.sv
`timescale 1ns/1ns
`default_nettype none

module axi_axil_adapter_rd_assertions (
  input wire                        clk,
  input wire                        i_reset,
  input wire                        i_arvalid,
  input wire axi_burst_pkg::len_t   i_arlen,
  input wire                        i_arready,
  input wire                        i_lite_arvalid,
  input wire axi_burst_pkg::addr_t  i_lite_araddr,
  input wire                        i_lite_arready,
  input wire                        i_rvalid,
  input wire                        i_rready,
  input wire axi_burst_pkg::id_t    i_rid,
  input wire axil_beat_pkg::data_t  i_rdata,
  input wire axil_beat_pkg::resp_t  i_rresp,
  input wire                        i_rlast
);

  // AXI-Lite reads still to be issued for the accepted burst
  logic [8:0] reads_due;

  always_ff @(posedge clk) begin
    if (i_reset) begin
      reads_due <= '0;
    end else if (i_arvalid && i_arready) begin
      reads_due <= {1'b0, i_arlen} + 9'd1;
    end else if (i_lite_arvalid && i_lite_arready) begin
      reads_due <= reads_due - 9'd1;
    end
  end

  // AXI-Lite AR holds valid and address until accepted
  lite_ar_hold: assert property (@(posedge clk) disable iff (i_reset)
    i_lite_arvalid && !i_lite_arready |=> i_lite_arvalid && $stable(i_lite_araddr))
    else $error("AXI-Lite AR dropped or changed before its handshake");

  // AXI R beat holds valid and payload until accepted
  r_hold: assert property (@(posedge clk) disable iff (i_reset)
    i_rvalid && !i_rready |=> i_rvalid && $stable({i_rid, i_rdata, i_rresp, i_rlast}))
    else $error("AXI R beat dropped or changed before its handshake");

  // No new burst while reads of the current one are still to be issued
  ar_between_bursts: assert property (@(posedge clk) disable iff (i_reset)
    !(i_arready && reads_due != '0))
    else $error("AXI AR ready while reads of a burst are still to be issued");

  reset_state: assert property (@(posedge clk)
    i_reset |=> !i_rvalid && !i_lite_arvalid && !i_rlast && i_arready)
    else $error("Outputs not at their idle values after reset");

endmodule

`default_nettype wire

// File: tb/axi_axil_adapter_rd_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "axi_rd_consts.svh"

module axi_axil_adapter_rd_tb;

  import axi_burst_pkg::*;
  import axil_beat_pkg::*;

  localparam logic [31:0] LFSR_SEED = 32'hbd4f_5616;
  // 44 beats over all tests with a wide margin per beat for random stalls
  localparam int TOTAL_BEATS = 44;
  localparam int TIMEOUT_CYCLES = TOTAL_BEATS * 450 + 200;

  logic   clk;
  logic   i_reset;
  logic   i_s_arvalid;
  id_t    i_s_arid;
  addr_t  i_s_araddr;
  len_t   i_s_arlen;
  size_t  i_s_arsize;
  burst_t i_s_arburst;
  logic   o_s_arready;
  logic   o_s_rvalid;
  id_t    o_s_rid;
  data_t  o_s_rdata;
  resp_t  o_s_rresp;
  logic   o_s_rlast;
  logic   i_s_rready;
  logic   o_m_arvalid;
  addr_t  o_m_araddr;
  logic   i_m_arready;
  logic   i_m_rvalid;
  data_t  i_m_rdata;
  resp_t  i_m_rresp;
  logic   o_m_rready;

  // Reads accepted by the memory, oldest first
  addr_t       mem_pend[$];
  logic        mem_random;
  logic [31:0] mem_lfsr;
  logic [31:0] rr_lfsr;

  id_t   exp_id[$];
  data_t exp_data[$];
  resp_t exp_resp[$];
  logic  exp_last[$];
  id_t   got_id[$];
  data_t got_data[$];
  resp_t got_resp[$];
  logic  got_last[$];

  int checked;
  int errors;
  int checks;
  int tests_run;
  int cycles;

  tb_clkgen clkgen_i (
    .clk     (clk),
    .o_reset (i_reset)
  );

  axi_axil_adapter_rd dut_i (
    .clk         (clk),
    .i_reset     (i_reset),
    .i_s_arvalid (i_s_arvalid),
    .i_s_arid    (i_s_arid),
    .i_s_araddr  (i_s_araddr),
    .i_s_arlen   (i_s_arlen),
    .i_s_arsize  (i_s_arsize),
    .i_s_arburst (i_s_arburst),
    .o_s_arready (o_s_arready),
    .o_s_rvalid  (o_s_rvalid),
    .o_s_rid     (o_s_rid),
    .o_s_rdata   (o_s_rdata),
    .o_s_rresp   (o_s_rresp),
    .o_s_rlast   (o_s_rlast),
    .i_s_rready  (i_s_rready),
    .o_m_arvalid (o_m_arvalid),
    .o_m_araddr  (o_m_araddr),
    .i_m_arready (i_m_arready),
    .i_m_rvalid  (i_m_rvalid),
    .i_m_rdata   (i_m_rdata),
    .i_m_rresp   (i_m_rresp),
    .o_m_rready  (o_m_rready)
  );

  bind axi_axil_adapter_rd axi_axil_adapter_rd_assertions assert_i (
    .clk            (clk),
    .i_reset        (i_reset),
    .i_arvalid      (i_s_arvalid),
    .i_arlen        (i_s_arlen),
    .i_arready      (o_s_arready),
    .i_lite_arvalid (o_m_arvalid),
    .i_lite_araddr  (o_m_araddr),
    .i_lite_arready (i_m_arready),
    .i_rvalid       (o_s_rvalid),
    .i_rready       (i_s_rready),
    .i_rid          (o_s_rid),
    .i_rdata        (o_s_rdata),
    .i_rresp        (o_s_rresp),
    .i_rlast        (o_s_rlast)
  );

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  // Address in the upper byte, its inverse in the lower byte
  function automatic data_t word_at(input addr_t a);
    return {a, ~a};
  endfunction

  function automatic resp_t resp_at(input addr_t a);
    return (a >= 8'hf0) ? `RESP_SLVERR : `RESP_OKAY;
  endfunction

  function automatic addr_t burst_beat_addr(input addr_t start, input len_t len,
                                            input size_t size, input burst_t burst,
                                            input int beat);
    int bytes;
    int win;
    int base;
    int off;
    bytes = 1 << size;
    case (burst)
      BURST_FIXED: begin
        return start;
      end
      BURST_WRAP: begin
        win = (int'(len) + 1) * bytes;
        base = (int'(start) / win) * win;
        off = (int'(start) - base + beat * bytes) % win;
        return addr_t'(base + off);
      end
      default: begin
        return addr_t'(int'(start) + beat * bytes);
      end
    endcase
  endfunction

  // AXI-Lite memory with optional random AR and R delays
  initial begin : axil_memory
    logic give;
    i_m_arready = 1'b0;
    i_m_rvalid = 1'b0;
    i_m_rdata = '0;
    i_m_rresp = '0;
    mem_lfsr = LFSR_SEED;
    forever begin
      @(posedge clk);
      if (i_reset) begin
        i_m_arready <= 1'b0;
        i_m_rvalid <= 1'b0;
        mem_pend.delete();
      end else begin
        if (o_m_arvalid && i_m_arready) begin
          mem_pend.push_back(o_m_araddr);
        end
        if (i_m_rvalid && o_m_rready) begin
          void'(mem_pend.pop_front());
          i_m_rvalid <= 1'b0;
        end
        // Next response only once the current one is gone
        if ((!i_m_rvalid || o_m_rready) && mem_pend.size() > 0) begin
          give = 1'b1;
          if (mem_random) begin
            mem_lfsr = lfsr_next(mem_lfsr);
            give = mem_lfsr[0];
          end
          if (give) begin
            i_m_rvalid <= 1'b1;
            i_m_rdata <= word_at(mem_pend[0]);
            i_m_rresp <= resp_at(mem_pend[0]);
          end
        end
        if (mem_random) begin
          mem_lfsr = lfsr_next(mem_lfsr);
          i_m_arready <= mem_lfsr[0];
        end else begin
          i_m_arready <= 1'b1;
        end
      end
    end
  end

  // R beats sampled mid-cycle, one edge before their handshake
  initial begin : r_monitor
    forever begin
      @(negedge clk);
      if (!i_reset && o_s_rvalid && i_s_rready) begin
        got_id.push_back(o_s_rid);
        got_data.push_back(o_s_rdata);
        got_resp.push_back(o_s_rresp);
        got_last.push_back(o_s_rlast);
      end
    end
  end

  initial begin : watchdog
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
    $display("Test failed");
    $finish;
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error: %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    tests_run++;
    if (errors == errs_before) begin
      $display("[%s] ok", name);
    end else begin
      $display("[%s] %0d mismatches", name, errors - errs_before);
    end
  endtask

  // Queues the expected beats, then holds AR until accepted
  task automatic issue_burst(input id_t id, input addr_t start, input len_t len,
                             input size_t size, input burst_t burst);
    addr_t a;
    for (int i = 0; i <= int'(len); i++) begin
      a = burst_beat_addr(start, len, size, burst, i);
      exp_id.push_back(id);
      exp_data.push_back(word_at(a));
      exp_resp.push_back(resp_at(a));
      exp_last.push_back(i == int'(len));
    end
    i_s_arvalid <= 1'b1;
    i_s_arid <= id;
    i_s_araddr <= start;
    i_s_arlen <= len;
    i_s_arsize <= size;
    i_s_arburst <= burst;
    @(posedge clk);
    while (!o_s_arready) @(posedge clk);
    i_s_arvalid <= 1'b0;
  endtask

  task automatic finish_bursts(input logic random_rready);
    while (got_data.size() < exp_data.size()) begin
      @(posedge clk);
      if (random_rready) begin
        rr_lfsr = lfsr_next(rr_lfsr);
        i_s_rready <= rr_lfsr[0];
      end
    end
    i_s_rready <= 1'b1;
    // Idle cycles expose any extra beat
    repeat (4) @(posedge clk);
    check_value("R beat count", 32'(got_data.size()), 32'(exp_data.size()));
    check_value("o_s_arready", 32'(o_s_arready), 32'd1);
    for (int i = checked; i < exp_data.size(); i++) begin
      check_value($sformatf("o_s_rid beat %0d", i - checked), 32'(got_id[i]), 32'(exp_id[i]));
      check_value($sformatf("o_s_rdata beat %0d", i - checked),
                  32'(got_data[i]), 32'(exp_data[i]));
      check_value($sformatf("o_s_rresp beat %0d", i - checked),
                  32'(got_resp[i]), 32'(exp_resp[i]));
      check_value($sformatf("o_s_rlast beat %0d", i - checked),
                  32'(got_last[i]), 32'(exp_last[i]));
    end
    checked = exp_data.size();
  endtask

  task automatic reset_and_single_beat();
    int errs_before;
    errs_before = errors;
    check_value("o_s_arready", 32'(o_s_arready), 32'd1);
    check_value("o_s_rvalid", 32'(o_s_rvalid), 32'd0);
    check_value("o_m_arvalid", 32'(o_m_arvalid), 32'd0);
    i_s_rready <= 1'b1;
    issue_burst(4'h3, 8'h34, 8'd0, 3'd1, BURST_INCR);
    // AXI-Lite AR follows one cycle after acceptance
    @(posedge clk);
    check_value("o_m_arvalid", 32'(o_m_arvalid), 32'd1);
    finish_bursts(1'b0);
    report_test("1 reset and single beat", errs_before);
  endtask

  task automatic incr_six_beats();
    int errs_before;
    errs_before = errors;
    issue_burst(4'h7, 8'h10, 8'd5, 3'd1, BURST_INCR);
    finish_bursts(1'b0);
    report_test("2 INCR burst of 6 beats", errs_before);
  endtask

  task automatic fixed_and_wrap();
    int errs_before;
    errs_before = errors;
    issue_burst(4'h2, 8'h52, 8'd3, 3'd1, BURST_FIXED);
    finish_bursts(1'b0);
    issue_burst(4'ha, 8'h26, 8'd3, 3'd1, BURST_WRAP);
    finish_bursts(1'b0);
    report_test("3 FIXED and WRAP bursts", errs_before);
  endtask

  task automatic slverr_crossing();
    int errs_before;
    errs_before = errors;
    issue_burst(4'h1, 8'hec, 8'd5, 3'd1, BURST_INCR);
    finish_bursts(1'b0);
    report_test("4 burst into SLVERR range", errs_before);
  endtask

  task automatic random_stalls();
    int errs_before;
    errs_before = errors;
    mem_random <= 1'b1;
    issue_burst(4'hc, 8'h60, 8'd15, 3'd1, BURST_INCR);
    finish_bursts(1'b1);
    mem_random <= 1'b0;
    report_test("5 random stalls on 16 beats", errs_before);
  endtask

  task automatic back_to_back_bursts();
    int errs_before;
    errs_before = errors;
    issue_burst(4'h5, 8'h40, 8'd3, 3'd1, BURST_INCR);
    issue_burst(4'h9, 8'h88, 8'd2, 3'd1, BURST_INCR);
    finish_bursts(1'b0);
    report_test("6 two bursts back to back", errs_before);
  endtask

  initial begin
    i_s_arvalid = 1'b0;
    i_s_arid = '0;
    i_s_araddr = '0;
    i_s_arlen = '0;
    i_s_arsize = '0;
    i_s_arburst = BURST_INCR;
    i_s_rready = 1'b0;
    mem_random = 1'b0;
    rr_lfsr = LFSR_SEED;
    checked = 0;
    errors = 0;
    checks = 0;
    tests_run = 0;
    @(posedge clk);
    while (i_reset) @(posedge clk);
    reset_and_single_beat();
    incr_six_beats();
    fixed_and_wrap();
    slverr_crossing();
    random_stalls();
    back_to_back_bursts();
    $display("Tests run: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+hdl
hdl/axi_burst_pkg.sv
hdl/axil_beat_pkg.sv
hdl/axi_burst_iter_ar.sv
hdl/axil_reflect_rd.sv
hdl/axi_axil_adapter_rd.sv
tb/tb_clkgen.sv
tb/axi_axil_adapter_rd_assertions.sv
tb/axi_axil_adapter_rd_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the AXI to AXI-Lite read adapter testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ns \
  --top-module axi_axil_adapter_rd_tb -f verilog.f -o sim_adapter_rd
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_adapter_rd > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

# The log decides the result
if grep -q "Test failed" "$LOG"; then
  exit 1
fi
exit 0
